// File: hw/aluDecode.sv
// ALU ixt decoder
`timescale 1ns/1ns

module aluDecode import aluPkg::*; (
	input logic [7:0] idUIxt,
	output logic qwordMode,
	output logic packedMode,
	output logic zextMode,
	output logic [3:0] opCode
);

	logic ixtQword;
	logic ixtZext;

	// width control bits
	assign ixtQword = idUIxt[ixtQwordBit];
	assign ixtZext = idUIxt[ixtZextBit];

	// condition code in bits 7..6 plays no part here
	assign opCode = idUIxt[3:0];

	always_comb begin
		qwordMode = 1'b0;
		packedMode = 1'b0;
		zextMode = 1'b0;
		case ({ixtQword, ixtZext})
			2'b11: begin
				// packed dword lanes
				packedMode = 1'b1;
			end
			2'b10: begin
				qwordMode = 1'b1;
			end
			2'b01: begin
				// 32-bit result, zero extended
				zextMode = 1'b1;
			end
			default: begin
				// 32-bit result, sign extended
				zextMode = 1'b0;
			end
		endcase
	end

endmodule

// File: hw/aluOutputStage.sv
// ALU output register
`timescale 1ns/1ns

module aluOutputStage import aluPkg::*, flagPkg::*; (
	input logic clock,
	input logic arstN,
	input logic exHold,
	input logic qwordMode,
	input logic packedMode,
	input logic zextMode,
	input logic [31:0] resLo,
	input logic [31:0] resHi,
	input aluWord_t resQ,
	input logic newTLo,
	input logic newTQ,
	input logic newS,
	input logic [3:0] newLane,
	input logic [flagCount-1:0] regInSrST,
	output aluWord_t regOutVal,
	output logic [flagCount-1:0] regOutSrST
);

	aluWord_t nextVal;
	logic [flagCount-1:0] nextSrST;

	// width formatting and status merge
	always_comb begin
		nextVal = '0;
		nextSrST = regInSrST;
		if (packedMode) begin
			nextVal.dword.hi = resHi;
			nextVal.dword.lo = resLo;
			nextSrST[flagT] = newTLo;
			nextSrST[flagS] = newS;
			nextSrST[flagO:flagP] = newLane;
		end else if (qwordMode) begin
			nextVal = resQ;
			nextSrST[flagT] = newTQ;
		end else begin
			// 32-bit result, extended into the upper half
			nextVal.dword.lo = resLo;
			nextVal.dword.hi = zextMode ? '0 : {laneWidth{resLo[laneWidth-1]}};
			nextSrST[flagT] = newTLo;
		end
	end

	// hold keeps the last result
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			regOutVal <= '0;
			regOutSrST <= '0;
		end else if (!exHold) begin
			regOutVal <= nextVal;
			regOutSrST <= nextSrST;
		end
	end

endmodule

// File: hw/aluPkg.sv
// ALU shared definitions
package aluPkg;

	// data path widths
	localparam int dataWidth = 64;
	localparam int laneWidth = 32;
	localparam int pieceWidth = 16;
	localparam int pieceCount = 4;

	// ixt word fields, bits 7..6 carry the condition code and are ignored
	localparam int ixtQwordBit = 5;
	localparam int ixtZextBit = 4;

	// operation codes, ixt bits 3..0
	localparam logic [3:0] opAdd = 4'h0;
	localparam logic [3:0] opSub = 4'h1;
	localparam logic [3:0] opAdc = 4'h2;
	localparam logic [3:0] opSbb = 4'h3;
	localparam logic [3:0] opTst = 4'h4;
	localparam logic [3:0] opAnd = 4'h5;
	localparam logic [3:0] opOr = 4'h6;
	localparam logic [3:0] opXor = 4'h7;
	localparam logic [3:0] opCmpNe = 4'h8;
	localparam logic [3:0] opCmpHs = 4'h9;
	localparam logic [3:0] opCmpGe = 4'hA;
	localparam logic [3:0] opRsvd = 4'hB;
	localparam logic [3:0] opCmpEq = 4'hC;
	localparam logic [3:0] opCmpHi = 4'hD;
	localparam logic [3:0] opCmpGt = 4'hE;
	localparam logic [3:0] opCselt = 4'hF;

	// one operand, seen as a qword or as two packed dword lanes
	typedef union packed {
		logic [dataWidth-1:0] qword;
		struct packed {
			logic [laneWidth-1:0] hi;
			logic [laneWidth-1:0] lo;
		} dword;
	} aluWord_t;

endpackage

// File: hw/aluResultSelect.sv
// ALU result and flag select
`timescale 1ns/1ns

module aluResultSelect import aluPkg::*, flagPkg::*; (
	input logic [3:0] opCode,
	input aluWord_t regValRs,
	input aluWord_t regValRt,
	input logic [flagCount-1:0] regInSrST,
	input logic [64:0] addSum0,
	input logic [64:0] addSum1,
	input logic [64:0] subSum0,
	input logic [64:0] subSum1,
	input logic [32:0] addHi0,
	input logic [32:0] addHi1,
	input logic [32:0] subHi0,
	input logic [32:0] subHi1,
	input logic zeroLo,
	input logic zeroHi,
	input logic zeroQ,
	input logic carryLo,
	input logic carryHi,
	input logic carryQ,
	input logic geLo,
	input logic geHi,
	input logic geQ,
	input logic [3:0] laneZero,
	input logic [3:0] laneCarry,
	input logic [3:0] laneGe,
	input logic tstZeroLo,
	input logic tstZeroHi,
	input logic tstZeroQ,
	input logic [3:0] tstLaneZero,
	output logic [31:0] resLo,
	output logic [31:0] resHi,
	output aluWord_t resQ,
	output logic newTLo,
	output logic newTQ,
	output logic newS,
	output logic [3:0] newLane
);

	logic srT;
	logic srS;
	logic [64:0] adcSum;
	logic [64:0] sbbSum;
	logic [32:0] adcHi;
	logic [32:0] sbbHi;
	logic adcCarryLo;
	logic sbbCarryLo;

	assign srT = regInSrST[flagT];
	assign srS = regInSrST[flagS];

	// carry-in from T or from S for the packed high lane
	assign adcSum = srT ? addSum1 : addSum0;
	assign adcHi = srS ? addHi1 : addHi0;
	// a set borrow means carry-in 0
	assign sbbSum = srT ? subSum0 : subSum1;
	assign sbbHi = srS ? subHi0 : subHi1;

	// low lane carry recovered from bit 32 of the full chain
	assign adcCarryLo = adcSum[laneWidth] ^ regValRs.dword.hi[0] ^ regValRt.dword.hi[0];
	assign sbbCarryLo = sbbSum[laneWidth] ^ regValRs.dword.hi[0] ^ ~regValRt.dword.hi[0];

	always_comb begin
		// flag-only and reserved ops leave a zero value
		resLo = '0;
		resHi = '0;
		resQ = '0;
		newTLo = srT;
		newTQ = srT;
		newS = srS;
		newLane = regInSrST[flagO:flagP];
		case (opCode)
			opAdd: begin
				resQ.qword = addSum0[dataWidth-1:0];
				resLo = addSum0[laneWidth-1:0];
				resHi = addHi0[laneWidth-1:0];
			end
			opSub: begin
				resQ.qword = subSum1[dataWidth-1:0];
				resLo = subSum1[laneWidth-1:0];
				resHi = subHi1[laneWidth-1:0];
			end
			opAdc: begin
				resQ.qword = adcSum[dataWidth-1:0];
				resLo = adcSum[laneWidth-1:0];
				resHi = adcHi[laneWidth-1:0];
				newTLo = adcCarryLo;
				newTQ = adcSum[dataWidth];
				newS = adcHi[laneWidth];
			end
			opSbb: begin
				resQ.qword = sbbSum[dataWidth-1:0];
				resLo = sbbSum[laneWidth-1:0];
				resHi = sbbHi[laneWidth-1:0];
				newTLo = !sbbCarryLo;
				newTQ = !sbbSum[dataWidth];
				newS = !sbbHi[laneWidth];
			end
			opTst: begin
				newTLo = tstZeroLo;
				newTQ = tstZeroQ;
				newS = tstZeroHi;
				newLane = tstLaneZero;
			end
			opAnd, opOr, opXor: begin
				if (opCode == opAnd)
					resQ.qword = regValRs.qword & regValRt.qword;
				else if (opCode == opOr)
					resQ.qword = regValRs.qword | regValRt.qword;
				else
					resQ.qword = regValRs.qword ^ regValRt.qword;
				resLo = resQ.dword.lo;
				resHi = resQ.dword.hi;
			end
			opCmpNe: begin
				newTLo = !zeroLo;
				newTQ = !zeroQ;
				newS = !zeroHi;
				newLane = ~laneZero;
			end
			opCmpHs: begin
				newTLo = carryLo;
				newTQ = carryQ;
				newS = carryHi;
				newLane = laneCarry;
			end
			opCmpGe: begin
				newTLo = geLo;
				newTQ = geQ;
				newS = geHi;
				newLane = laneGe;
			end
			opCmpEq: begin
				newTLo = zeroLo;
				newTQ = zeroQ;
				newS = zeroHi;
				newLane = laneZero;
			end
			opCmpHi: begin
				newTLo = carryLo && !zeroLo;
				newTQ = carryQ && !zeroQ;
				newS = carryHi && !zeroHi;
				newLane = laneCarry & ~laneZero;
			end
			opCmpGt: begin
				newTLo = geLo && !zeroLo;
				newTQ = geQ && !zeroQ;
				newS = geHi && !zeroHi;
				newLane = laneGe & ~laneZero;
			end
			opCselt: begin
				resQ = srT ? regValRs : regValRt;
				resLo = srT ? regValRs.dword.lo : regValRt.dword.lo;
				resHi = srS ? regValRs.dword.hi : regValRt.dword.hi;
			end
			opRsvd: begin
				// reserved op keeps the incoming flags
			end
		endcase
	end

endmodule

// File: hw/carrySelectAdder.sv
// Carry-select adder
`timescale 1ns/1ns

module carrySelectAdder import aluPkg::*; (
	input aluWord_t regValRs,
	input aluWord_t regValRt,
	output logic [64:0] addSum0,
	output logic [64:0] addSum1,
	output logic [64:0] subSum0,
	output logic [64:0] subSum1,
	output logic [32:0] addHi0,
	output logic [32:0] addHi1,
	output logic [32:0] subHi0,
	output logic [32:0] subHi1,
	output logic [3:0][16:0] subPiece
);

	logic [pieceCount-1:0][pieceWidth:0] addP0;
	logic [pieceCount-1:0][pieceWidth:0] addP1;
	logic [pieceCount-1:0][pieceWidth:0] subP0;
	logic [pieceCount-1:0][pieceWidth:0] subP1;
	logic [laneWidth:0] addLo0;
	logic [laneWidth:0] addLo1;
	logic [laneWidth:0] subLo0;
	logic [laneWidth:0] subLo1;

	// upper piece picked by the carry out of the lower one
	function automatic logic [32:0] joinPair(
		input logic [16:0] low,
		input logic [16:0] high0,
		input logic [16:0] high1
	);
		joinPair = {low[16] ? high1 : high0, low[15:0]};
	endfunction

	// each 16-bit piece for carry-in 0 and 1
	always_comb begin
		for (int i = 0; i < pieceCount; i++) begin
			addP0[i] = {1'b0, regValRs.qword[i*pieceWidth +: pieceWidth]} +
				{1'b0, regValRt.qword[i*pieceWidth +: pieceWidth]};
			addP1[i] = addP0[i] + 17'd1;
			subP0[i] = {1'b0, regValRs.qword[i*pieceWidth +: pieceWidth]} +
				{1'b0, ~regValRt.qword[i*pieceWidth +: pieceWidth]};
			subP1[i] = subP0[i] + 17'd1;
		end
	end

	// 32-bit stage
	assign addLo0 = joinPair(addP0[0], addP0[1], addP1[1]);
	assign addLo1 = joinPair(addP1[0], addP0[1], addP1[1]);
	assign subLo0 = joinPair(subP0[0], subP0[1], subP1[1]);
	assign subLo1 = joinPair(subP1[0], subP0[1], subP1[1]);

	// high lane chained on its own, also used by packed mode
	assign addHi0 = joinPair(addP0[2], addP0[3], addP1[3]);
	assign addHi1 = joinPair(addP1[2], addP0[3], addP1[3]);
	assign subHi0 = joinPair(subP0[2], subP0[3], subP1[3]);
	assign subHi1 = joinPair(subP1[2], subP0[3], subP1[3]);

	// 64-bit stage
	assign addSum0 = {addLo0[laneWidth] ? addHi1 : addHi0, addLo0[laneWidth-1:0]};
	assign addSum1 = {addLo1[laneWidth] ? addHi1 : addHi0, addLo1[laneWidth-1:0]};
	assign subSum0 = {subLo0[laneWidth] ? subHi1 : subHi0, subLo0[laneWidth-1:0]};
	assign subSum1 = {subLo1[laneWidth] ? subHi1 : subHi0, subLo1[laneWidth-1:0]};

	// independent 16-bit differences for the lane compares
	assign subPiece = subP1;

endmodule

// File: hw/compareFlags.sv
// Compare and test flags
`timescale 1ns/1ns

module compareFlags import aluPkg::*; (
	input aluWord_t regValRs,
	input aluWord_t regValRt,
	input logic [64:0] subSum1,
	input logic [32:0] subHi1,
	input logic [3:0][16:0] subPiece,
	output logic zeroLo,
	output logic zeroHi,
	output logic zeroQ,
	output logic carryLo,
	output logic carryHi,
	output logic carryQ,
	output logic geLo,
	output logic geHi,
	output logic geQ,
	output logic [3:0] laneZero,
	output logic [3:0] laneCarry,
	output logic [3:0] laneGe,
	output logic tstZeroLo,
	output logic tstZeroHi,
	output logic tstZeroQ,
	output logic [3:0] tstLaneZero
);

	// signed Rs >= Rt from the operand signs and the difference sign
	function automatic logic signedGe(
		input logic rsSign,
		input logic rtSign,
		input logic diffSign
	);
		logic ovf;
		ovf = (!rsSign && rtSign && diffSign) || (rsSign && !rtSign && !diffSign);
		return !(diffSign ^ ovf);
	endfunction

	assign zeroLo = (subSum1[laneWidth-1:0] == '0);
	assign zeroHi = (subHi1[laneWidth-1:0] == '0);
	assign zeroQ = (subSum1[dataWidth-1:0] == '0);

	// carry out of the low half, recovered from sum bit 32
	assign carryLo = subSum1[laneWidth] ^ regValRs.dword.hi[0] ^ ~regValRt.dword.hi[0];
	assign carryHi = subHi1[laneWidth];
	assign carryQ = subSum1[dataWidth];

	assign geLo = signedGe(regValRs.dword.lo[laneWidth-1], regValRt.dword.lo[laneWidth-1],
		subSum1[laneWidth-1]);
	assign geHi = signedGe(regValRs.dword.hi[laneWidth-1], regValRt.dword.hi[laneWidth-1],
		subHi1[laneWidth-1]);
	assign geQ = signedGe(regValRs.qword[dataWidth-1], regValRt.qword[dataWidth-1],
		subSum1[dataWidth-1]);

	// 16-bit lane flags
	always_comb begin
		for (int i = 0; i < pieceCount; i++) begin
			laneZero[i] = (subPiece[i][pieceWidth-1:0] == '0);
			laneCarry[i] = subPiece[i][pieceWidth];
			laneGe[i] = signedGe(regValRs.qword[i*pieceWidth + pieceWidth-1],
				regValRt.qword[i*pieceWidth + pieceWidth-1], subPiece[i][pieceWidth-1]);
			tstLaneZero[i] = ((regValRs.qword[i*pieceWidth +: pieceWidth] &
				regValRt.qword[i*pieceWidth +: pieceWidth]) == '0);
		end
	end

	// TST zero flags built from the lanes
	assign tstZeroLo = &tstLaneZero[1:0];
	assign tstZeroHi = &tstLaneZero[3:2];
	assign tstZeroQ = &tstLaneZero;

endmodule

// File: hw/exAlu.sv
// Execute unit ALU
`timescale 1ns/1ns

module exAlu import aluPkg::*, flagPkg::*; (
	input logic clock,
	input logic arstN,
	input aluWord_t regValRs,
	input aluWord_t regValRt,
	input logic [7:0] idUIxt,
	input logic exHold,
	input logic [flagCount-1:0] regInSrST,
	output aluWord_t regOutVal,
	output logic [flagCount-1:0] regOutSrST
);

	logic qwordMode;
	logic packedMode;
	logic zextMode;
	logic [3:0] opCode;
	logic [64:0] addSum0;
	logic [64:0] addSum1;
	logic [64:0] subSum0;
	logic [64:0] subSum1;
	logic [32:0] addHi0;
	logic [32:0] addHi1;
	logic [32:0] subHi0;
	logic [32:0] subHi1;
	logic [3:0][16:0] subPiece;
	logic zeroLo;
	logic zeroHi;
	logic zeroQ;
	logic carryLo;
	logic carryHi;
	logic carryQ;
	logic geLo;
	logic geHi;
	logic geQ;
	logic [3:0] laneZero;
	logic [3:0] laneCarry;
	logic [3:0] laneGe;
	logic tstZeroLo;
	logic tstZeroHi;
	logic tstZeroQ;
	logic [3:0] tstLaneZero;
	logic [31:0] resLo;
	logic [31:0] resHi;
	aluWord_t resQ;
	logic newTLo;
	logic newTQ;
	logic newS;
	logic [3:0] newLane;

	aluDecode i_aluDecode (
		.idUIxt(idUIxt),
		.qwordMode(qwordMode),
		.packedMode(packedMode),
		.zextMode(zextMode),
		.opCode(opCode)
	);

	carrySelectAdder i_carrySelectAdder (
		.regValRs(regValRs),
		.regValRt(regValRt),
		.addSum0(addSum0),
		.addSum1(addSum1),
		.subSum0(subSum0),
		.subSum1(subSum1),
		.addHi0(addHi0),
		.addHi1(addHi1),
		.subHi0(subHi0),
		.subHi1(subHi1),
		.subPiece(subPiece)
	);

	compareFlags i_compareFlags (
		.regValRs(regValRs),
		.regValRt(regValRt),
		.subSum1(subSum1),
		.subHi1(subHi1),
		.subPiece(subPiece),
		.zeroLo(zeroLo),
		.zeroHi(zeroHi),
		.zeroQ(zeroQ),
		.carryLo(carryLo),
		.carryHi(carryHi),
		.carryQ(carryQ),
		.geLo(geLo),
		.geHi(geHi),
		.geQ(geQ),
		.laneZero(laneZero),
		.laneCarry(laneCarry),
		.laneGe(laneGe),
		.tstZeroLo(tstZeroLo),
		.tstZeroHi(tstZeroHi),
		.tstZeroQ(tstZeroQ),
		.tstLaneZero(tstLaneZero)
	);

	aluResultSelect i_aluResultSelect (
		.opCode(opCode),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.regInSrST(regInSrST),
		.addSum0(addSum0),
		.addSum1(addSum1),
		.subSum0(subSum0),
		.subSum1(subSum1),
		.addHi0(addHi0),
		.addHi1(addHi1),
		.subHi0(subHi0),
		.subHi1(subHi1),
		.zeroLo(zeroLo),
		.zeroHi(zeroHi),
		.zeroQ(zeroQ),
		.carryLo(carryLo),
		.carryHi(carryHi),
		.carryQ(carryQ),
		.geLo(geLo),
		.geHi(geHi),
		.geQ(geQ),
		.laneZero(laneZero),
		.laneCarry(laneCarry),
		.laneGe(laneGe),
		.tstZeroLo(tstZeroLo),
		.tstZeroHi(tstZeroHi),
		.tstZeroQ(tstZeroQ),
		.tstLaneZero(tstLaneZero),
		.resLo(resLo),
		.resHi(resHi),
		.resQ(resQ),
		.newTLo(newTLo),
		.newTQ(newTQ),
		.newS(newS),
		.newLane(newLane)
	);

	aluOutputStage i_aluOutputStage (
		.clock(clock),
		.arstN(arstN),
		.exHold(exHold),
		.qwordMode(qwordMode),
		.packedMode(packedMode),
		.zextMode(zextMode),
		.resLo(resLo),
		.resHi(resHi),
		.resQ(resQ),
		.newTLo(newTLo),
		.newTQ(newTQ),
		.newS(newS),
		.newLane(newLane),
		.regInSrST(regInSrST),
		.regOutVal(regOutVal),
		.regOutSrST(regOutSrST)
	);

endmodule

// File: hw/flagPkg.sv
// Status word layout
package flagPkg;

	// number of status bits handled by the ALU
	localparam int flagCount = 6;

	// T is the main predicate bit
	localparam int flagT = 0;

	// S is the predicate of the packed high lane
	localparam int flagS = 1;

	// P..O hold the four 16-bit lane predicates in packed mode
	localparam int flagP = 2;
	localparam int flagQ = 3;
	localparam int flagR = 4;
	localparam int flagO = 5;

endpackage

// File: list.f
hw/aluPkg.sv
hw/flagPkg.sv
hw/aluDecode.sv
hw/carrySelectAdder.sv
hw/compareFlags.sv
hw/aluResultSelect.sv
hw/aluOutputStage.sv
hw/exAlu.sv
tb/exAlu_checker.sv
tb/exAluTb.sv

// File: run.sh
#!/bin/sh
# build and run the exAlu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exAluTb -f list.f -o exAluSim
if ./obj_dir/exAluSim > sim.log 2>&1; then
	simStatus=0
else
	simStatus=1
fi
cat sim.log
if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "simulator exited with an error"
	exit 1
fi

// File: tb/exAluTb.sv
// ALU testbench
`timescale 1ns/1ns

module exAluTb import aluPkg::*, flagPkg::*; ();

	localparam int halfPeriod = 20;
	localparam int resetCycles = 10;
	localparam int randPerOp = 8;
	localparam int logicVectors = 3 * 6 * randPerOp;
	localparam int carryVectors = 2 * 2 * 2 * 6;
	localparam int compareVectors = 4 * 7 * 8;
	localparam int packedVectors = 8 * randPerOp;
	localparam int holdVectors = 8;
	localparam int totalCycles = resetCycles + logicVectors + carryVectors +
		compareVectors + packedVectors + holdVectors;
	// one clock period per vector, plus 100 spare cycles
	localparam int watchdogNs = (totalCycles + 100) * 2 * halfPeriod;

	logic clock;
	logic arstN;
	aluWord_t regValRs;
	aluWord_t regValRt;
	logic [7:0] idUIxt;
	logic exHold;
	logic [flagCount-1:0] regInSrST;
	aluWord_t regOutVal;
	logic [flagCount-1:0] regOutSrST;
	logic [31:0] randState = 32'hac53;
	int valErrors = 0;
	int flagErrors = 0;

	exAlu i_exAlu (
		.clock(clock),
		.arstN(arstN),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.idUIxt(idUIxt),
		.exHold(exHold),
		.regInSrST(regInSrST),
		.regOutVal(regOutVal),
		.regOutSrST(regOutSrST)
	);

	bind exAlu exAlu_checker i_checker (
		.clock(clock),
		.arstN(arstN),
		.exHold(exHold),
		.regOutVal(regOutVal),
		.regOutSrST(regOutSrST)
	);

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	initial begin
		#(watchdogNs);
		$display("timeout: the tests did not finish within %0d ns", watchdogNs);
		$display("Result: FAILED");
		$finish;
	end

	// xorshift generator
	function automatic logic [31:0] nextRand();
		randState = randState ^ (randState << 13);
		randState = randState ^ (randState >> 17);
		randState = randState ^ (randState << 5);
		return randState;
	endfunction

	function automatic aluWord_t randWord();
		aluWord_t w;
		w.dword.hi = nextRand();
		w.dword.lo = nextRand();
		return w;
	endfunction

	function automatic logic [flagCount-1:0] randStatus();
		logic [31:0] r;
		r = nextRand();
		return r[flagCount-1:0];
	endfunction

	function automatic logic isFlagOp(input logic [3:0] op);
		return op inside {opTst, opCmpNe, opCmpHs, opCmpGe, opCmpEq, opCmpHi, opCmpGt};
	endfunction

	// one operation at width w, returns {flag, value}
	function automatic logic [64:0] evalOp(input logic [3:0] op, input int w,
		input logic [63:0] a, input logic [63:0] b, input logic fin);
		logic [63:0] mask;
		logic [63:0] sgn;
		logic [64:0] wa;
		logic [64:0] wb;
		logic [64:0] wide;
		logic [63:0] val;
		logic flag;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		sgn = 64'd1 << (w - 1);
		wa = {1'b0, a & mask};
		wb = {1'b0, b & mask};
		val = '0;
		flag = fin;
		case (op)
			opAdd: val = a + b;
			opSub: val = a - b;
			opAdc: begin
				wide = wa + wb + {64'd0, fin};
				val = wide[63:0];
				flag = |(wide & ~{1'b0, mask});
			end
			opSbb: begin
				val = a - b - {63'd0, fin};
				flag = (wa < wb + {64'd0, fin});
			end
			opTst: flag = ((a & b & mask) == 64'd0);
			opAnd: val = a & b;
			opOr: val = a | b;
			opXor: val = a ^ b;
			opCmpNe: flag = (wa != wb);
			opCmpEq: flag = (wa == wb);
			opCmpHs: flag = (wa >= wb);
			opCmpHi: flag = (wa > wb);
			// signed order by flipping the sign bit
			opCmpGe: flag = (((a ^ sgn) & mask) >= ((b ^ sgn) & mask));
			opCmpGt: flag = (((a ^ sgn) & mask) > ((b ^ sgn) & mask));
			opCselt: val = fin ? a : b;
			default: val = '0;
		endcase
		return {flag, val & mask};
	endfunction

	// reference model of the registered result
	task automatic predict(input aluWord_t rs, input aluWord_t rt, input logic [7:0] ixt,
		input logic [flagCount-1:0] sr, output aluWord_t val,
		output logic [flagCount-1:0] srOut);
		logic [64:0] lo;
		logic [64:0] hi;
		logic [64:0] lane;
		logic [3:0] op;
		op = ixt[3:0];
		srOut = sr;
		val = '0;
		if (ixt[ixtQwordBit] && ixt[ixtZextBit]) begin
			lo = evalOp(op, laneWidth, {32'd0, rs.dword.lo}, {32'd0, rt.dword.lo}, sr[flagT]);
			hi = evalOp(op, laneWidth, {32'd0, rs.dword.hi}, {32'd0, rt.dword.hi}, sr[flagS]);
			val.dword.lo = lo[31:0];
			val.dword.hi = hi[31:0];
			srOut[flagT] = lo[64];
			srOut[flagS] = hi[64];
			if (isFlagOp(op)) begin
				for (int i = 0; i < pieceCount; i++) begin
					lane = evalOp(op, pieceWidth, {48'd0, rs.qword[i*pieceWidth +: pieceWidth]},
						{48'd0, rt.qword[i*pieceWidth +: pieceWidth]}, sr[flagP + i]);
					srOut[flagP + i] = lane[64];
				end
			end
		end else if (ixt[ixtQwordBit]) begin
			lo = evalOp(op, dataWidth, rs.qword, rt.qword, sr[flagT]);
			val.qword = lo[63:0];
			srOut[flagT] = lo[64];
		end else begin
			lo = evalOp(op, laneWidth, {32'd0, rs.dword.lo}, {32'd0, rt.dword.lo}, sr[flagT]);
			val.dword.lo = lo[31:0];
			val.dword.hi = ixt[ixtZextBit] ? 32'd0 : {32{lo[31]}};
			srOut[flagT] = lo[64];
		end
	endtask

	task automatic compareVal(input string name, input aluWord_t got, input aluWord_t exp);
		if (got !== exp) begin
			valErrors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compareFlags(input string name, input logic [flagCount-1:0] got,
		input logic [flagCount-1:0] exp);
		if (got !== exp) begin
			flagErrors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// called on a falling edge, checks on the next one
	task automatic runVector(input aluWord_t rs, input aluWord_t rt, input logic [7:0] ixt,
		input logic [flagCount-1:0] sr);
		aluWord_t expVal;
		logic [flagCount-1:0] expSr;
		predict(rs, rt, ixt, sr, expVal, expSr);
		regValRs = rs;
		regValRt = rt;
		idUIxt = ixt;
		regInSrST = sr;
		exHold = 1'b0;
		@(negedge clock);
		compareVal("regOutVal", regOutVal, expVal);
		compareFlags("regOutSrST", regOutSrST, expSr);
	endtask

	task automatic resetTest();
		// busy inputs, so a cleared output means something
		regValRs = 64'h0123_4567_89ab_cdef;
		regValRt = 64'hfedc_ba98_7654_3210;
		idUIxt = {2'b00, 2'b10, opAdd};
		regInSrST = '1;
		exHold = 1'b0;
		arstN = 1'b0;
		repeat (resetCycles) @(negedge clock);
		compareVal("regOutVal", regOutVal, '0);
		compareFlags("regOutSrST", regOutSrST, '0);
		arstN = 1'b1;
	endtask

	task automatic logicTest();
		logic [3:0] ops [6] = '{opAdd, opSub, opAnd, opOr, opXor, opCselt};
		logic [1:0] modes [3] = '{2'b00, 2'b01, 2'b10};
		logic [31:0] r;
		for (int m = 0; m < 3; m++) begin
			for (int k = 0; k < 6; k++) begin
				for (int n = 0; n < randPerOp; n++) begin
					// random condition code bits
					r = nextRand();
					runVector(randWord(), randWord(), {r[7:6], modes[m], ops[k]}, randStatus());
				end
			end
		end
	endtask

	task automatic carryTest();
		logic [3:0] ops [2] = '{opAdc, opSbb};
		logic [1:0] modes [2] = '{2'b00, 2'b10};
		aluWord_t rsTab [6];
		aluWord_t rtTab [6];
		logic [flagCount-1:0] sr;
		rsTab[0] = '1;
		rtTab[0] = 64'd1;
		rsTab[1] = '0;
		rtTab[1] = 64'd1;
		rsTab[2] = 64'h0000_0000_ffff_ffff;
		rtTab[2] = '0;
		rsTab[3] = 64'h0000_0001_0000_0000;
		rtTab[3] = 64'h0000_0000_ffff_ffff;
		for (int i = 4; i < 6; i++) begin
			rsTab[i] = randWord();
			rtTab[i] = randWord();
		end
		for (int m = 0; m < 2; m++) begin
			for (int k = 0; k < 2; k++) begin
				for (int t = 0; t < 2; t++) begin
					for (int i = 0; i < 6; i++) begin
						sr = randStatus();
						sr[flagT] = t[0];
						runVector(rsTab[i], rtTab[i], {2'b00, modes[m], ops[k]}, sr);
					end
				end
			end
		end
	endtask

	task automatic compareTest();
		logic [3:0] ops [7] = '{opCmpNe, opCmpHs, opCmpGe, opCmpEq, opCmpHi, opCmpGt, opTst};
		aluWord_t rsTab [8];
		aluWord_t rtTab [8];
		rsTab[0] = randWord();
		rtTab[0] = rsTab[0];
		// sign boundary in every lane width
		rsTab[1] = 64'h8000_8000_8000_8000;
		rtTab[1] = 64'h7fff_7fff_7fff_7fff;
		rsTab[2] = rtTab[1];
		rtTab[2] = rsTab[1];
		rsTab[3] = '1;
		rtTab[3] = '0;
		rsTab[4] = '0;
		rtTab[4] = '1;
		rsTab[5] = 64'h0001_8000_ffff_0000;
		rtTab[5] = 64'h0001_7fff_0000_0000;
		rsTab[6] = randWord();
		rtTab[6] = randWord();
		rsTab[7] = randWord();
		rtTab[7].qword = rsTab[7].qword ^ 64'h1;
		for (int m = 0; m < 4; m++) begin
			for (int k = 0; k < 7; k++) begin
				for (int i = 0; i < 8; i++) begin
					runVector(rsTab[i], rtTab[i], {2'b00, m[1:0], ops[k]}, randStatus());
				end
			end
		end
	endtask

	task automatic packedTest();
		logic [3:0] ops [8] = '{opAdd, opSub, opAdc, opSbb, opAnd, opXor, opCselt, opRsvd};
		for (int k = 0; k < 8; k++) begin
			for (int n = 0; n < randPerOp; n++) begin
				runVector(randWord(), randWord(), {2'b00, 2'b11, ops[k]}, randStatus());
			end
		end
	endtask

	task automatic holdTest();
		aluWord_t rs;
		aluWord_t rt;
		aluWord_t keepVal;
		logic [flagCount-1:0] sr;
		logic [flagCount-1:0] keepSr;
		rs = randWord();
		rt = randWord();
		sr = randStatus();
		predict(rs, rt, {2'b00, 2'b10, opAdd}, sr, keepVal, keepSr);
		runVector(rs, rt, {2'b00, 2'b10, opAdd}, sr);
		// inputs keep moving while the register is held
		for (int n = 0; n < 6; n++) begin
			regValRs = randWord();
			regValRt = randWord();
			regInSrST = randStatus();
			idUIxt = {2'b00, 2'b11, opSub};
			exHold = 1'b1;
			@(negedge clock);
			compareVal("regOutVal", regOutVal, keepVal);
			compareFlags("regOutSrST", regOutSrST, keepSr);
		end
		runVector(randWord(), randWord(), {2'b00, 2'b01, opXor}, randStatus());
	endtask

	initial begin
		arstN = 1'b0;
		exHold = 1'b0;
		regValRs = '0;
		regValRt = '0;
		idUIxt = '0;
		regInSrST = '0;
		resetTest();
		logicTest();
		carryTest();
		compareTest();
		packedTest();
		holdTest();
		$display("errors: value %0d, status %0d", valErrors, flagErrors);
		if (valErrors + flagErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: tb/exAlu_checker.sv
// ALU output register checks
`timescale 1ns/1ns

module exAlu_checker import aluPkg::*, flagPkg::*; (
	input logic clock,
	input logic arstN,
	input logic exHold,
	input aluWord_t regOutVal,
	input logic [flagCount-1:0] regOutSrST
);

	// outputs cleared while reset is held
	resetClears: assert property (@(posedge clock)
		!arstN |-> (regOutVal == '0 && regOutSrST == '0))
		else $error("outputs not zero while reset is asserted");

	// a held edge leaves the register untouched
	holdKeeps: assert property (@(posedge clock) disable iff (!arstN)
		exHold |=> ($stable(regOutVal) && $stable(regOutSrST)))
		else $error("outputs changed on an edge with hold asserted");

endmodule
